//--- compile.f
mdll_pkg.sv
mdll_sdm.sv
mdll_dither_lfsr.sv
mdll_fb_divider.sv
mdll_ctrl_fsm.sv
mdll_frac_div.sv
tb_mdll_frac_div.sv

//--- Bender.yml
package:
  name: mdll_frac_div

sources:
  - mdll_pkg.sv
  - mdll_sdm.sv
  - mdll_dither_lfsr.sv
  - mdll_fb_divider.sv
  - mdll_ctrl_fsm.sv
  - mdll_frac_div.sv
  - target: test
    files:
      - tb_mdll_frac_div.sv

//--- tb_mdll_frac_div.sv
`timescale 1ns/1ns
module tb_mdll_frac_div
	import mdll_pkg::*;
();

	logic clk;
	logic rstn;
	logic cfg_load;
	logic en_sdm;
	logic en_dither;
	logic [N_INT-1:0] fcw_int;
	logic [N_DI-1:0] fcw_frac;
	logic fb_pulse;
	logic running;
	logic [N_DO-1:0] sdm_out;

	string test_name;	// shown in error lines
	logic pulse_d;	// fb_pulse one cycle back

	mdll_frac_div dut0 (
		.clk       (clk),
		.rstn      (rstn),
		.cfg_load  (cfg_load),
		.en_sdm    (en_sdm),
		.en_dither (en_dither),
		.fcw_int   (fcw_int),
		.fcw_frac  (fcw_frac),
		.fb_pulse  (fb_pulse),
		.running   (running),
		.sdm_out   (sdm_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	// ----------------------------------------
	// error exits
	// ----------------------------------------
	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string what, input int exp, input int act);
		$display("[ERROR] %s (%s): expected %0d, actual %0d", test_name, what, exp, act);
		abort_run();
	endtask

	task automatic plain_error(input string what);
		$display("[ERROR] %s: %s", test_name, what);
		abort_run();
	endtask

	// ----------------------------------------
	// stimulus and waits
	// ----------------------------------------
	// gap to the next strobe in cycles since the previous return
	task automatic wait_pulse(output int gap);
		int n;
		n = 0;
		gap = 0;
		while (gap == 0) begin
			@(negedge clk);
			n++;
			assert (running) else plain_error("running dropped while waiting for fb_pulse");
			if (fb_pulse) begin
				gap = n;
			end else if (n >= 200) begin
				plain_error("no fb_pulse within 200 cycles");
			end
		end
	endtask

	// one-cycle load strobe then wait for running
	task automatic load_cfg(input int fi, input int ff, input bit sdm, input bit dith);
		int n;
		@(negedge clk);
		cfg_load  = 1'b1;
		fcw_int   = N_INT'(fi);
		fcw_frac  = N_DI'(ff);
		en_sdm    = sdm;
		en_dither = dith;
		@(negedge clk);
		cfg_load = 1'b0;
		fcw_int  = N_INT'($urandom);	// scrambled so only latched words count
		fcw_frac = N_DI'($urandom);
		n = 1;
		while (!running) begin
			assert (!fb_pulse) else plain_error("fb_pulse during restart");
			if (n >= 200) begin
				plain_error("running did not rise within 200 cycles");
			end
			@(negedge clk);
			n++;
		end
		assert (!fb_pulse) else plain_error("fb_pulse on first run cycle");
		assert (n == 2) else mismatch("cycles from cfg_load to running", 2, n);
	endtask

	// each gap is fi plus the offset shown at the earlier strobe
	task automatic run_periods(input int fi, input bit frac_on, input int n, output int sum);
		int gap;
		int off;
		int exp_gap;
		sum = 0;
		off = sdm_out;	// reload value at run start
		for (int i = 0; i < n; i++) begin
			wait_pulse(gap);
			exp_gap = frac_on ? fi + off : fi;
			assert (gap == exp_gap) else mismatch("pulse interval", exp_gap, gap);
			off = sdm_out;	// offset of the period now starting
			sum += off;
			if (!frac_on) begin
				assert (off == 0) else mismatch("sdm_out with modulator off", 0, off);
			end
		end
	endtask

	// ----------------------------------------
	// always-on checks
	// ----------------------------------------
	always @(negedge clk) begin
		if (rstn) begin
			assert (!(fb_pulse && pulse_d)) else plain_error("fb_pulse high two cycles in a row");
			assert (!fb_pulse || running) else plain_error("fb_pulse while not running");
		end
		pulse_d <= fb_pulse;
	end

	initial begin
		int fi;
		int ff;
		int sum;
		int d;
		rstn      = 1'b0;
		cfg_load  = 1'b0;
		en_sdm    = 1'b0;
		en_dither = 1'b0;
		fcw_int   = N_INT'(2);
		fcw_frac  = '0;
		void'($urandom(32'h7ba5));	// single seed for the whole run
		test_name = "reset";
		repeat (8) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);
		assert (running == 1'b0) else mismatch("running after reset", 0, running);
		assert (fb_pulse == 1'b0) else mismatch("fb_pulse after reset", 0, fb_pulse);
		assert (sdm_out == '0) else mismatch("sdm_out after reset", 0, sdm_out);
		for (int i = 0; i < 50; i++) begin	// idle window without load
			@(negedge clk);
			assert (!fb_pulse) else plain_error("fb_pulse without cfg_load");
		end

		test_name = "integer division";
		for (int k = 0; k < 4; k++) begin
			fi = 2 + $urandom % 19;
			ff = $urandom % 32;	// ignored with modulator off
			load_cfg(fi, ff, 1'b0, 1'b0);
			run_periods(fi, 1'b0, 20, sum);
		end

		test_name = "fractional division";
		for (int k = 0; k < 4; k++) begin
			fi = 2 + $urandom % 19;
			ff = $urandom % 32;
			load_cfg(fi, ff, 1'b1, 1'b0);
			run_periods(fi, 1'b1, 32, sum);
			assert (sum >= ff - 1 && sum <= ff + 1) else mismatch("sdm_out sum over 32", ff, sum);
		end

		// mean offset still ff/32 as the noise only spreads it
		test_name = "dither";
		for (int k = 0; k < 2; k++) begin
			fi = 2 + $urandom % 19;
			ff = $urandom % 32;
			load_cfg(fi, ff, 1'b1, 1'b1);
			run_periods(fi, 1'b1, 256, sum);
			assert (sum >= 8 * ff - 16 && sum <= 8 * ff + 16)
				else mismatch("sdm_out sum over 256", 8 * ff, sum);
		end

		test_name = "reload mid-run";
		fi = 2 + $urandom % 19;
		load_cfg(fi, $urandom % 32, 1'b1, 1'b0);
		run_periods(fi, 1'b1, 8, sum);
		for (int k = 0; k < 3; k++) begin
			d = 1 + $urandom % (fi - 1);	// land inside the current period
			repeat (d - 1) @(negedge clk);
			fi = 2 + $urandom % 19;
			load_cfg(fi, $urandom % 32, 1'b1, 1'b0);
			run_periods(fi, 1'b1, 8, sum);
		end

		$display("Test passed");
		$finish;
	end

endmodule

//--- mdll_frac_div.sv
`timescale 1ns/1ns
module mdll_frac_div
	import mdll_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic cfg_load,	// one cycle strobe that restarts from any state
	input  logic en_sdm,
	input  logic en_dither,
	input  logic [N_INT-1:0] fcw_int,	// at least 2
	input  logic [N_DI-1:0] fcw_frac,
	output logic fb_pulse,	// one per divider period
	output logic running,
	output logic [N_DO-1:0] sdm_out	// offset of the period just begun
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic clr;
	logic run;
	logic sdm_on;
	logic dither_on;
	logic [N_INT-1:0] int_q;
	logic [N_DI-1:0] frac_q;
	logic step;	// divider terminal count
	logic [N_DO-1:0] dout;	// modulator offset
	logic signed [N_DI-1:0] dither;

	mdll_ctrl_fsm u_ctrl (
		.clk       (clk),
		.rstn      (rstn),
		.cfg_load  (cfg_load),
		.en_sdm    (en_sdm),
		.en_dither (en_dither),
		.fcw_int   (fcw_int),
		.fcw_frac  (fcw_frac),
		.clr       (clr),
		.run       (run),
		.sdm_on    (sdm_on),
		.dither_on (dither_on),
		.int_q     (int_q),
		.frac_q    (frac_q)
	);

	mdll_fb_divider u_div (
		.clk    (clk),
		.rstn   (rstn),
		.clr    (clr),
		.run    (run),
		.n_int  (int_q),
		.offset (dout),	// reload uses the offset of this same step
		.step   (step)
	);

	mdll_sdm u_sdm (
		.clk    (clk),
		.rstn   (rstn),
		.clr    (clr),
		.step   (step),
		.en_sdm (sdm_on),
		.din    (frac_q),
		.dither (dither),
		.dout   (dout)
	);

	mdll_dither_lfsr u_dither (
		.clk       (clk),
		.rstn      (rstn),
		.clr       (clr),
		.step      (step),
		.en_dither (dither_on),
		.dither    (dither)
	);

	assign fb_pulse = step;
	assign running  = run;
	assign sdm_out  = dout;

endmodule

//--- mdll_ctrl_fsm.sv
`timescale 1ns/1ns
module mdll_ctrl_fsm
	import mdll_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic cfg_load,	// one cycle strobe
	input  logic en_sdm,
	input  logic en_dither,
	input  logic [N_INT-1:0] fcw_int,
	input  logic [N_DI-1:0] fcw_frac,
	output logic clr,	// one cycle datapath clear
	output logic run,	// divider enable
	output logic sdm_on,
	output logic dither_on,
	output logic [N_INT-1:0] int_q,
	output logic [N_DI-1:0] frac_q
);

	logic [1:0] state;
	logic [1:0] state_nx;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				if (cfg_load) state_nx = st_clear;
			end
			st_clear: begin
				state_nx = st_run;	// clear lasts one cycle
				if (cfg_load) state_nx = st_clear;
			end
			st_run: begin
				if (cfg_load) state_nx = st_clear;	// abort and restart
			end
			default: begin
				state_nx = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= st_idle;
			sdm_on    <= 1'b0;
			dither_on <= 1'b0;
		end else begin
			state <= state_nx;
			if (cfg_load) begin
				sdm_on    <= en_sdm;
				dither_on <= en_dither;
			end
		end
	end

	// config words, captured with the load strobe
	always_ff @(posedge clk) begin
		if (cfg_load) begin
			int_q  <= fcw_int;
			frac_q <= fcw_frac;
		end
	end

	assign clr = (state == st_clear);
	assign run = (state == st_run);

endmodule

//--- mdll_fb_divider.sv
`timescale 1ns/1ns
module mdll_fb_divider
	import mdll_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic clr,	// forces count to zero
	input  logic run,	// level enable from control
	input  logic [N_INT-1:0] n_int,
	input  logic [N_DO-1:0] offset,	// sampled at each reload
	output logic step	// terminal count strobe
);

	logic [N_INT:0] cnt;	// extra bit since n_int + offset can carry
	logic [N_INT:0] period;
	logic active;

	// ----------------------------------------
	// reload value
	// ----------------------------------------
	assign period = {1'b0, n_int} + (N_INT+1)'(offset);

	assign active = run && !clr;

	// one pulse per period, at count 1
	assign step = active && (cnt == (N_INT+1)'(1));

	// ----------------------------------------
	// down-counter
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt <= '0;
		end else if (!active) begin
			cnt <= '0;	// idle or clearing
		end else if (cnt == '0) begin
			cnt <= period;	// first run cycle
		end else if (step) begin
			cnt <= period;	// back to back periods
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// count 0 is only seen on the first run cycle
	// so pulse spacing is exactly period cycles

endmodule

//--- mdll_dither_lfsr.sv
`timescale 1ns/1ns
module mdll_dither_lfsr
	import mdll_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic clr,	// back to seed
	input  logic step,	// shift once per divider period
	input  logic en_dither,
	output logic signed [N_DI-1:0] dither	// -4 .. +4
);

	logic [DITHER_W-1:0] lfsr;
	logic fb;	// feedback bit
	logic signed [N_DI-1:0] raw;	// low bits read as signed
	logic signed [N_DI:0] rnd;	// raw plus half lsb of the shifted word
	logic signed [N_DI:0] shd;

	// ----------------------------------------
	// x^16 + x^15 + x^13 + x^4 + 1
	// ----------------------------------------
	assign fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lfsr <= DITHER_SEED;
		end else if (clr) begin
			lfsr <= DITHER_SEED;
		end else if (step) begin
			lfsr <= {lfsr[DITHER_W-2:0], fb};
		end
	end

	// rounding keeps the mean at zero
	assign raw = lfsr[N_DI-1:0];
	assign rnd = $signed({raw[N_DI-1], raw}) + $signed((N_DI+1)'(1 << (DITHER_SH - 1)));
	assign shd = rnd >>> DITHER_SH;

	assign dither = en_dither ? shd[N_DI-1:0] : '0;	// zero when off

endmodule

//--- mdll_sdm.sv
`timescale 1ns/1ns
module mdll_sdm
	import mdll_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic clr,	// restart clears loop state
	input  logic step,	// advance once per divider period
	input  logic en_sdm,
	input  logic [N_DI-1:0] din,	// fractional word
	input  logic signed [N_DI-1:0] dither,
	output logic [N_DO-1:0] dout	// offset for the period now starting
);

	logic signed [N_DI+1:0] qin;	// quantizer input with two guard bits
	logic signed [N_DI+1:0] qin_d;	// qin one step back
	logic signed [N_DI+1:0] qsh;	// qin scaled down by 2**MODULO
	logic [N_DO-1:0] qout;
	logic [N_DI-1:0] dac;	// feedback value
	logic [N_DI-1:0] dac_d;	// dac one step back

	// ----------------------------------------
	// loop sum and quantizer
	// ----------------------------------------
	assign qin = $signed({2'b00, din}) + qin_d
		+ $signed({{2{dither[N_DI-1]}}, dither})
		- $signed({2'b00, dac_d});

	assign qsh = qin >>> MODULO;

	// top N_DO bits of the low N_DI bits
	// saturates when dither pushes qin out of range
	always_comb begin
		if (qsh < 0) begin
			qout = '0;
		end else if (qsh > (2 ** N_DO - 1)) begin
			qout = '1;
		end else begin
			qout = qsh[N_DO-1:0];
		end
	end

	assign dac  = {qout, {MODULO{1'b0}}};	// qout << MODULO
	assign dout = en_sdm ? qout : '0;

	// state moves only on step
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			qin_d <= '0;
			dac_d <= '0;
		end else if (clr) begin
			qin_d <= '0;
			dac_d <= '0;
		end else if (step) begin
			qin_d <= qin;
			dac_d <= dac;
		end
	end

endmodule

//--- mdll_pkg.sv
package mdll_pkg;

	// ----------------------------------------
	// word widths
	// ----------------------------------------
	localparam int N_DI   = 6;	// fractional word and dither word
	localparam int N_DO   = 1;	// modulator offset
	localparam int MODULO = N_DI - N_DO;	// 2**MODULO is the quantizer step
	localparam int N_INT  = 8;	// integer division word

	// ----------------------------------------
	// dither source
	// ----------------------------------------
	localparam int DITHER_W = 16;	// lfsr length
	localparam logic [DITHER_W-1:0] DITHER_SEED = 16'hace1;	// any nonzero value
	localparam int DITHER_SH = 3;	// 6b signed word down to +/-4

	// ----------------------------------------
	// control fsm states
	// ----------------------------------------
	localparam logic [1:0] st_idle  = 2'd0;	// waiting for first load
	localparam logic [1:0] st_clear = 2'd1;	// one cycle datapath clear
	localparam logic [1:0] st_run   = 2'd2;	// divider running

endpackage
